//--- vlog.f
+incdir+.
axil_pkg.sv
spill_register.sv
axil_cut.sv
axil_regfile.sv
axil_regblock_top.sv
tb_axil_regblock_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the register block testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  --timescale 1ns/1ps \
  -f vlog.f \
  --top-module tb_axil_regblock_top \
  -o tb_sim

# A failing check ends in $fatal, which gives a non-zero exit status
./obj_dir/tb_sim

//--- tb_axil_regblock_top.sv
/*
 * Testbench for the AXI4-Lite register block
 * Random write and read bursts under B/R back-pressure, checked against a model
 */
`timescale 1ns/1ps
`include "axil_settings.svh"

module tb_axil_regblock_top;

  import axil_pkg::*;

  localparam int TIMEOUT = 200;

  logic       clk_i;
  logic       arst_n_i;
  logic       slv_aw_valid_i, slv_aw_ready_o;
  axil_addr_t slv_aw_addr_i;
  logic       slv_w_valid_i, slv_w_ready_o;
  axil_data_t slv_w_data_i;
  axil_strb_t slv_w_strb_i;
  logic       slv_b_valid_o, slv_b_ready_i;
  axil_resp_t slv_b_resp_o;
  logic       slv_ar_valid_i, slv_ar_ready_o;
  axil_addr_t slv_ar_addr_i;
  logic       slv_r_valid_o, slv_r_ready_i;
  axil_data_t slv_r_data_o;
  axil_resp_t slv_r_resp_o;

  // Reference model and expected responses in request order
  axil_data_t model_q [`AXIL_NUM_REGS];
  b_chan_t    exp_b_q [$];
  r_chan_t    exp_r_q [$];
  b_chan_t    got_b;
  r_chan_t    got_r;
  integer     seed;
  bit         stall_en;

  axil_regblock_top u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_b(input b_chan_t act, input b_chan_t exp);
    if (act.resp !== exp.resp) begin
      abort_run($sformatf("MISMATCH at %0t: slv_b_resp_o got %0h expected %0h",
                          $time, act.resp, exp.resp));
    end
  endtask

  task automatic check_r(input r_chan_t act, input r_chan_t exp);
    if (act.data !== exp.data) begin
      abort_run($sformatf("MISMATCH at %0t: slv_r_data_o got %0h expected %0h",
                          $time, act.data, exp.data));
    end else if (act.resp !== exp.resp) begin
      abort_run($sformatf("MISMATCH at %0t: slv_r_resp_o got %0h expected %0h",
                          $time, act.resp, exp.resp));
    end
  endtask

  // Strobed write into the model with SLVERR above the last word
  function automatic b_chan_t model_write(axil_addr_t addr, axil_data_t data, axil_strb_t strb);
    b_chan_t rsp;
    int      idx;
    idx = int'(addr) / 4;
    if (idx < `AXIL_NUM_REGS) begin
      for (int i = 0; i < `AXIL_STRB_WIDTH; i++) begin
        if (strb[i]) begin
          model_q[idx][8*i +: 8] = data[8*i +: 8];
        end
      end
      rsp.resp = RESP_OKAY;
    end else begin
      rsp.resp = RESP_SLVERR;
    end
    return rsp;
  endfunction

  function automatic r_chan_t model_read(axil_addr_t addr);
    r_chan_t rsp;
    int      idx;
    idx = int'(addr) / 4;
    if (idx < `AXIL_NUM_REGS) begin
      rsp.data = model_q[idx];
      rsp.resp = RESP_OKAY;
    end else begin
      rsp.data = '0;
      rsp.resp = RESP_SLVERR;
    end
    return rsp;
  endfunction

  // Called just after a rising edge; AW and W may complete on different edges
  task automatic write_req(input axil_addr_t addr, input axil_data_t data, input axil_strb_t strb);
    bit aw_done;
    bit w_done;
    int cycles;
    aw_done = 1'b0;
    w_done  = 1'b0;
    cycles  = 0;
    slv_aw_valid_i = 1'b1;
    slv_aw_addr_i  = addr;
    slv_w_valid_i  = 1'b1;
    slv_w_data_i   = data;
    slv_w_strb_i   = strb;
    while (!(aw_done && w_done)) begin
      @(negedge clk_i);
      if (slv_aw_valid_i && slv_aw_ready_o) aw_done = 1'b1;
      if (slv_w_valid_i && slv_w_ready_o) w_done = 1'b1;
      @(posedge clk_i);
      #1;
      if (aw_done) slv_aw_valid_i = 1'b0;
      if (w_done) slv_w_valid_i = 1'b0;
      cycles++;
      if (cycles > TIMEOUT && !(aw_done && w_done)) begin
        abort_run("Timeout: AW or W was never accepted");
      end
    end
    exp_b_q.push_back(model_write(addr, data, strb));
  endtask

  task automatic read_req(input axil_addr_t addr);
    bit ar_done;
    int cycles;
    ar_done = 1'b0;
    cycles  = 0;
    slv_ar_valid_i = 1'b1;
    slv_ar_addr_i  = addr;
    while (!ar_done) begin
      @(negedge clk_i);
      if (slv_ar_ready_o) ar_done = 1'b1;
      @(posedge clk_i);
      #1;
      if (ar_done) slv_ar_valid_i = 1'b0;
      cycles++;
      if (cycles > TIMEOUT && !ar_done) begin
        abort_run("Timeout: AR was never accepted");
      end
    end
    exp_r_q.push_back(model_read(addr));
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_b_q.size() != 0 || exp_r_q.size() != 0) begin
      @(posedge clk_i);
      #1;
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run("Timeout: outstanding responses never returned");
      end
    end
  endtask

  // Handshakes are judged at the falling edge, before the edge that transfers them
  initial begin
    forever begin
      @(negedge clk_i);
      if (arst_n_i && slv_b_valid_o && slv_b_ready_i) begin
        got_b.resp = slv_b_resp_o;
        if (exp_b_q.size() == 0) begin
          abort_run("Write response arrived with no write outstanding");
        end else begin
          check_b(got_b, exp_b_q.pop_front());
        end
      end
      if (arst_n_i && slv_r_valid_o && slv_r_ready_i) begin
        got_r.data = slv_r_data_o;
        got_r.resp = slv_r_resp_o;
        if (exp_r_q.size() == 0) begin
          abort_run("Read response arrived with no read outstanding");
        end else begin
          check_r(got_r, exp_r_q.pop_front());
        end
      end
    end
  end

  // Random back-pressure on B and R, drawn at the falling edge
  initial begin
    bit b_rdy;
    bit r_rdy;
    slv_b_ready_i = 1'b1;
    slv_r_ready_i = 1'b1;
    forever begin
      @(negedge clk_i);
      b_rdy = !stall_en || (($random(seed) & 3) != 0);
      r_rdy = !stall_en || (($random(seed) & 3) != 0);
      @(posedge clk_i);
      #1;
      slv_b_ready_i = b_rdy;
      slv_r_ready_i = r_rdy;
    end
  end

  initial begin
    int         n;
    axil_strb_t strb;
    seed           = 32'h8c4;
    stall_en       = 1'b0;
    arst_n_i       = 1'b0;
    slv_aw_valid_i = 1'b0;
    slv_aw_addr_i  = '0;
    slv_w_valid_i  = 1'b0;
    slv_w_data_i   = '0;
    slv_w_strb_i   = '0;
    slv_ar_valid_i = 1'b0;
    slv_ar_addr_i  = '0;
    for (int i = 0; i < `AXIL_NUM_REGS; i++) begin
      model_q[i] = '0;
    end
    repeat (4) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;

    // Idle after reset, no response may appear
    repeat (5) begin
      @(negedge clk_i);
      if (slv_b_valid_o || slv_r_valid_o) begin
        abort_run("Response valid raised while the bus was idle after reset");
      end
    end
    @(posedge clk_i);
    #1;
    for (int i = 0; i < `AXIL_NUM_REGS; i++) begin
      read_req(axil_addr_t'(i * 4));
    end
    wait_drain();

    // Bursts of writes then reads, several in flight at once
    stall_en = 1'b1;
    for (int round = 0; round < 40; round++) begin
      n = 1 + int'($unsigned($random(seed)) % 6);
      repeat (n) begin
        strb = axil_strb_t'($random(seed));
        if (($random(seed) & 1) != 0) strb = {`AXIL_STRB_WIDTH{1'b1}};
        write_req(axil_addr_t'($unsigned($random(seed)) % 48),
                  axil_data_t'($random(seed)), strb);
      end
      wait_drain();
      repeat (n + 2) begin
        read_req(axil_addr_t'($unsigned($random(seed)) % 48));
      end
      wait_drain();
    end

    // Final sweep confirms no out-of-range write touched a register
    for (int a = 0; a < 48; a += 4) begin
      read_req(axil_addr_t'(a));
    end
    wait_drain();

    // No duplicate may follow the last response
    repeat (8) begin
      @(negedge clk_i);
      if (slv_b_valid_o || slv_r_valid_o) begin
        abort_run("Response valid raised after every response had returned");
      end
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- axil_regblock_top.sv
/*
 * AXI4-Lite register block
 * Manager traffic passes a full cut before reaching the register file
 */
`timescale 1ns/1ps
`include "axil_settings.svh"

module axil_regblock_top (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 slv_aw_valid_i,
  output logic                 slv_aw_ready_o,
  input  axil_pkg::axil_addr_t slv_aw_addr_i,
  input  logic                 slv_w_valid_i,
  output logic                 slv_w_ready_o,
  input  axil_pkg::axil_data_t slv_w_data_i,
  input  axil_pkg::axil_strb_t slv_w_strb_i,
  output logic                 slv_b_valid_o,
  input  logic                 slv_b_ready_i,
  output axil_pkg::axil_resp_t slv_b_resp_o,
  input  logic                 slv_ar_valid_i,
  output logic                 slv_ar_ready_o,
  input  axil_pkg::axil_addr_t slv_ar_addr_i,
  output logic                 slv_r_valid_o,
  input  logic                 slv_r_ready_i,
  output axil_pkg::axil_data_t slv_r_data_o,
  output axil_pkg::axil_resp_t slv_r_resp_o
);

  import axil_pkg::*;

  // Register-file side of the cut
  logic       mst_aw_valid, mst_aw_ready;
  axil_addr_t mst_aw_addr;
  logic       mst_w_valid, mst_w_ready;
  axil_data_t mst_w_data;
  axil_strb_t mst_w_strb;
  logic       mst_b_valid, mst_b_ready;
  axil_resp_t mst_b_resp;
  logic       mst_ar_valid, mst_ar_ready;
  axil_addr_t mst_ar_addr;
  logic       mst_r_valid, mst_r_ready;
  axil_data_t mst_r_data;
  axil_resp_t mst_r_resp;

  axil_cut #(.bypass(`AXIL_BYPASS)) u_cut (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .slv_aw_valid_i (slv_aw_valid_i),
    .slv_aw_ready_o (slv_aw_ready_o),
    .slv_aw_addr_i  (slv_aw_addr_i),
    .slv_w_valid_i  (slv_w_valid_i),
    .slv_w_ready_o  (slv_w_ready_o),
    .slv_w_data_i   (slv_w_data_i),
    .slv_w_strb_i   (slv_w_strb_i),
    .slv_b_valid_o  (slv_b_valid_o),
    .slv_b_ready_i  (slv_b_ready_i),
    .slv_b_resp_o   (slv_b_resp_o),
    .slv_ar_valid_i (slv_ar_valid_i),
    .slv_ar_ready_o (slv_ar_ready_o),
    .slv_ar_addr_i  (slv_ar_addr_i),
    .slv_r_valid_o  (slv_r_valid_o),
    .slv_r_ready_i  (slv_r_ready_i),
    .slv_r_data_o   (slv_r_data_o),
    .slv_r_resp_o   (slv_r_resp_o),
    .mst_aw_valid_o (mst_aw_valid),
    .mst_aw_ready_i (mst_aw_ready),
    .mst_aw_addr_o  (mst_aw_addr),
    .mst_w_valid_o  (mst_w_valid),
    .mst_w_ready_i  (mst_w_ready),
    .mst_w_data_o   (mst_w_data),
    .mst_w_strb_o   (mst_w_strb),
    .mst_b_valid_i  (mst_b_valid),
    .mst_b_ready_o  (mst_b_ready),
    .mst_b_resp_i   (mst_b_resp),
    .mst_ar_valid_o (mst_ar_valid),
    .mst_ar_ready_i (mst_ar_ready),
    .mst_ar_addr_o  (mst_ar_addr),
    .mst_r_valid_i  (mst_r_valid),
    .mst_r_ready_o  (mst_r_ready),
    .mst_r_data_i   (mst_r_data),
    .mst_r_resp_i   (mst_r_resp)
  );

  axil_regfile u_regfile (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .aw_valid_i (mst_aw_valid),
    .aw_ready_o (mst_aw_ready),
    .aw_addr_i  (mst_aw_addr),
    .w_valid_i  (mst_w_valid),
    .w_ready_o  (mst_w_ready),
    .w_data_i   (mst_w_data),
    .w_strb_i   (mst_w_strb),
    .b_valid_o  (mst_b_valid),
    .b_ready_i  (mst_b_ready),
    .b_resp_o   (mst_b_resp),
    .ar_valid_i (mst_ar_valid),
    .ar_ready_o (mst_ar_ready),
    .ar_addr_i  (mst_ar_addr),
    .r_valid_o  (mst_r_valid),
    .r_ready_i  (mst_r_ready),
    .r_data_o   (mst_r_data),
    .r_resp_o   (mst_r_resp)
  );

endmodule

//--- axil_regfile.sv
/*
 * AXI4-Lite register file
 * Strobed word writes, word reads, SLVERR outside the register range
 */
`timescale 1ns/1ps
`include "axil_settings.svh"

module axil_regfile (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 aw_valid_i,
  output logic                 aw_ready_o,
  input  axil_pkg::axil_addr_t aw_addr_i,
  input  logic                 w_valid_i,
  output logic                 w_ready_o,
  input  axil_pkg::axil_data_t w_data_i,
  input  axil_pkg::axil_strb_t w_strb_i,
  output logic                 b_valid_o,
  input  logic                 b_ready_i,
  output axil_pkg::axil_resp_t b_resp_o,
  input  logic                 ar_valid_i,
  output logic                 ar_ready_o,
  input  axil_pkg::axil_addr_t ar_addr_i,
  output logic                 r_valid_o,
  input  logic                 r_ready_i,
  output axil_pkg::axil_data_t r_data_o,
  output axil_pkg::axil_resp_t r_resp_o
);

  import axil_pkg::*;

  localparam int OFF_W = $clog2(`AXIL_STRB_WIDTH);
  localparam int IDX_W = $clog2(`AXIL_NUM_REGS);
  localparam axil_addr_t REG_SPAN = axil_addr_t'(`AXIL_NUM_REGS * `AXIL_STRB_WIDTH);

  axil_data_t       regs_q [`AXIL_NUM_REGS];
  logic             b_valid_q;
  axil_resp_t       b_resp_q;
  logic             r_valid_q;
  axil_data_t       r_data_q;
  axil_resp_t       r_resp_q;
  logic             wr_en;
  logic             rd_en;
  logic             wr_hit;
  logic             rd_hit;
  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] rd_idx;

  // AW and W are taken together, never while a B is still waiting
  assign aw_ready_o = w_valid_i && !b_valid_q;
  assign w_ready_o  = aw_valid_i && !b_valid_q;
  assign wr_en      = aw_valid_i && w_valid_i && !b_valid_q;
  assign ar_ready_o = !r_valid_q;
  assign rd_en      = ar_valid_i && !r_valid_q;

  // Word index sits above the byte offset
  assign wr_idx = aw_addr_i[OFF_W +: IDX_W];
  assign rd_idx = ar_addr_i[OFF_W +: IDX_W];
  assign wr_hit = aw_addr_i < REG_SPAN;
  assign rd_hit = ar_addr_i < REG_SPAN;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < `AXIL_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en && wr_hit) begin
      for (int b = 0; b < `AXIL_STRB_WIDTH; b++) begin
        if (w_strb_i[b]) begin
          regs_q[wr_idx][8*b +: 8] <= w_data_i[8*b +: 8];
        end
      end
    end
  end

  // Response valids stay up until the cut takes them
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (wr_en) begin
        b_valid_q <= 1'b1;
      end else if (b_ready_i) begin
        b_valid_q <= 1'b0;
      end
      if (rd_en) begin
        r_valid_q <= 1'b1;
      end else if (r_ready_i) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      b_resp_q <= wr_hit ? RESP_OKAY : RESP_SLVERR;
    end
    if (rd_en) begin
      r_data_q <= rd_hit ? regs_q[rd_idx] : '0;
      r_resp_q <= rd_hit ? RESP_OKAY : RESP_SLVERR;
    end
  end

  assign b_valid_o = b_valid_q;
  assign b_resp_o  = b_resp_q;
  assign r_valid_o = r_valid_q;
  assign r_data_o  = r_data_q;
  assign r_resp_o  = r_resp_q;

endmodule

//--- axil_cut.sv
/*
 * AXI4-Lite cut
 * One spill register per channel, no combinational path from port to port
 */
`timescale 1ns/1ps

module axil_cut #(
  parameter bit bypass = 1'b0
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  // Port facing the outside manager
  input  logic               slv_aw_valid_i,
  output logic               slv_aw_ready_o,
  input  axil_pkg::axil_addr_t slv_aw_addr_i,
  input  logic               slv_w_valid_i,
  output logic               slv_w_ready_o,
  input  axil_pkg::axil_data_t slv_w_data_i,
  input  axil_pkg::axil_strb_t slv_w_strb_i,
  output logic               slv_b_valid_o,
  input  logic               slv_b_ready_i,
  output axil_pkg::axil_resp_t slv_b_resp_o,
  input  logic               slv_ar_valid_i,
  output logic               slv_ar_ready_o,
  input  axil_pkg::axil_addr_t slv_ar_addr_i,
  output logic               slv_r_valid_o,
  input  logic               slv_r_ready_i,
  output axil_pkg::axil_data_t slv_r_data_o,
  output axil_pkg::axil_resp_t slv_r_resp_o,
  // Port facing the register file
  output logic               mst_aw_valid_o,
  input  logic               mst_aw_ready_i,
  output axil_pkg::axil_addr_t mst_aw_addr_o,
  output logic               mst_w_valid_o,
  input  logic               mst_w_ready_i,
  output axil_pkg::axil_data_t mst_w_data_o,
  output axil_pkg::axil_strb_t mst_w_strb_o,
  input  logic               mst_b_valid_i,
  output logic               mst_b_ready_o,
  input  axil_pkg::axil_resp_t mst_b_resp_i,
  output logic               mst_ar_valid_o,
  input  logic               mst_ar_ready_i,
  output axil_pkg::axil_addr_t mst_ar_addr_o,
  input  logic               mst_r_valid_i,
  output logic               mst_r_ready_o,
  input  axil_pkg::axil_data_t mst_r_data_i,
  input  axil_pkg::axil_resp_t mst_r_resp_i
);

  import axil_pkg::*;

  aw_chan_t slv_aw, mst_aw;
  w_chan_t  slv_w,  mst_w;
  b_chan_t  slv_b,  mst_b;
  ar_chan_t slv_ar, mst_ar;
  r_chan_t  slv_r,  mst_r;

  // Requests flow slv to mst
  assign slv_aw = '{addr: slv_aw_addr_i};
  assign slv_w  = '{data: slv_w_data_i, strb: slv_w_strb_i};
  assign slv_ar = '{addr: slv_ar_addr_i};
  assign mst_aw_addr_o = mst_aw.addr;
  assign mst_w_data_o  = mst_w.data;
  assign mst_w_strb_o  = mst_w.strb;
  assign mst_ar_addr_o = mst_ar.addr;

  // Responses flow mst to slv
  assign mst_b = '{resp: mst_b_resp_i};
  assign mst_r = '{data: mst_r_data_i, resp: mst_r_resp_i};
  assign slv_b_resp_o = slv_b.resp;
  assign slv_r_data_o = slv_r.data;
  assign slv_r_resp_o = slv_r.resp;

  spill_register #(.T(aw_chan_t), .bypass(bypass)) u_reg_aw (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (slv_aw_valid_i),
    .ready_o  (slv_aw_ready_o),
    .data_i   (slv_aw),
    .valid_o  (mst_aw_valid_o),
    .ready_i  (mst_aw_ready_i),
    .data_o   (mst_aw)
  );

  spill_register #(.T(w_chan_t), .bypass(bypass)) u_reg_w (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (slv_w_valid_i),
    .ready_o  (slv_w_ready_o),
    .data_i   (slv_w),
    .valid_o  (mst_w_valid_o),
    .ready_i  (mst_w_ready_i),
    .data_o   (mst_w)
  );

  spill_register #(.T(b_chan_t), .bypass(bypass)) u_reg_b (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (mst_b_valid_i),
    .ready_o  (mst_b_ready_o),
    .data_i   (mst_b),
    .valid_o  (slv_b_valid_o),
    .ready_i  (slv_b_ready_i),
    .data_o   (slv_b)
  );

  spill_register #(.T(ar_chan_t), .bypass(bypass)) u_reg_ar (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (slv_ar_valid_i),
    .ready_o  (slv_ar_ready_o),
    .data_i   (slv_ar),
    .valid_o  (mst_ar_valid_o),
    .ready_i  (mst_ar_ready_i),
    .data_o   (mst_ar)
  );

  spill_register #(.T(r_chan_t), .bypass(bypass)) u_reg_r (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (mst_r_valid_i),
    .ready_o  (mst_r_ready_o),
    .data_i   (mst_r),
    .valid_o  (slv_r_valid_o),
    .ready_i  (slv_r_ready_i),
    .data_o   (slv_r)
  );

endmodule

//--- spill_register.sv
/*
 * Spill register
 * Two-slot elastic buffer that registers valid, ready and data paths
 */
`timescale 1ns/1ps

module spill_register #(
  parameter type T      = logic,
  parameter bit  bypass = 1'b0
) (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  if (bypass) begin : g_bypass
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : g_spill
    // Slot A drives the output, slot B only holds an item while A stalls
    logic a_full_q;
    logic b_full_q;
    T     a_data_q;
    T     b_data_q;
    logic in_xfer;
    logic out_xfer;
    logic a_load_in;
    logic a_load_b;
    logic b_load;

    assign in_xfer  = valid_i && !b_full_q;
    assign out_xfer = a_full_q && ready_i;

    // Incoming item goes to A if A is free or drains this cycle
    assign a_load_in = in_xfer && (!a_full_q || out_xfer);
    assign a_load_b  = b_full_q && out_xfer;
    assign b_load    = in_xfer && a_full_q && !out_xfer;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        if (a_load_in || a_load_b) begin
          a_full_q <= 1'b1;
        end else if (out_xfer) begin
          a_full_q <= 1'b0;
        end

        if (b_load) begin
          b_full_q <= 1'b1;
        end else if (a_load_b) begin
          b_full_q <= 1'b0;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_load_b) begin
        a_data_q <= b_data_q;
      end else if (a_load_in) begin
        a_data_q <= data_i;
      end
      if (b_load) begin
        b_data_q <= data_i;
      end
    end

    // B empty is a flop, so ready_i never reaches ready_o
    assign ready_o = !b_full_q;
    assign valid_o = a_full_q;
    assign data_o  = a_data_q;
  end

endmodule

//--- axil_pkg.sv
/*
 * AXI4-Lite types
 * Scalar payload types, response codes and per-channel structs
 */
`include "axil_settings.svh"

package axil_pkg;

  typedef logic [`AXIL_ADDR_WIDTH-1:0] axil_addr_t;
  typedef logic [`AXIL_DATA_WIDTH-1:0] axil_data_t;
  typedef logic [`AXIL_STRB_WIDTH-1:0] axil_strb_t;
  typedef logic [1:0]                  axil_resp_t;

  localparam axil_resp_t RESP_OKAY   = 2'b00;
  localparam axil_resp_t RESP_SLVERR = 2'b10;

  // Channel payloads as they travel through one spill register
  typedef struct packed {
    axil_addr_t addr;
  } aw_chan_t;

  typedef struct packed {
    axil_data_t data;
    axil_strb_t strb;
  } w_chan_t;

  typedef struct packed {
    axil_resp_t resp;
  } b_chan_t;

  typedef struct packed {
    axil_addr_t addr;
  } ar_chan_t;

  typedef struct packed {
    axil_data_t data;
    axil_resp_t resp;
  } r_chan_t;

endpackage

//--- axil_settings.svh
/*
 * AXI4-Lite register block settings
 * Bus widths, register count and the default bypass of the cut
 */
`ifndef AXIL_SETTINGS_SVH
`define AXIL_SETTINGS_SVH

`define AXIL_ADDR_WIDTH 8
`define AXIL_DATA_WIDTH 32
`define AXIL_STRB_WIDTH (`AXIL_DATA_WIDTH / 8)
// Eight words cover byte addresses 0 to 31
`define AXIL_NUM_REGS 8
`define AXIL_BYPASS 1'b0

`endif
